/* scaler_settings.svh */
// Size macros for the multi-channel gain scaler
// Included by both packages and by every module that needs a size
`ifndef SCALER_SETTINGS_SVH
`define SCALER_SETTINGS_SVH

`define SCALER_LANES      4   // Channels, one lane each
`define SCALER_DATA_W     16  // Signed sample width
`define SCALER_GAIN_W     10  // Signed gain width
`define SCALER_FRAC_BITS  6   // Gain fraction bits, 1.0 is 64
`define SCALER_LANE_LAT   3   // Lane depth in enabled cycles

// Channel index width, at least one bit
`define SCALER_CHAN_W     ((`SCALER_LANES > 1) ? $clog2(`SCALER_LANES) : 1)

// Full product width before rounding
`define SCALER_PROD_W     (`SCALER_DATA_W + `SCALER_GAIN_W)

`endif

/* scaler_cfg_pkg.sv */
// Gain bank types for the scaler
// Gain format and the write strobe that loads one lane's gain and bypass
`include "scaler_settings.svh"

package scaler_cfg_pkg;

    // Signed fixed point, FRAC_BITS below the binary point
    typedef logic signed [`SCALER_GAIN_W-1:0] gain_t;

    // Unity gain, loaded into every lane at reset
    localparam gain_t GAIN_ONE = gain_t'(1 << `SCALER_FRAC_BITS);

    // One write to the gain bank
    typedef struct packed {
        logic                       we;      // One-cycle strobe
        logic [`SCALER_CHAN_W-1:0]  lane;    // Target lane
        gain_t                      gain;    // New gain
        logic                       bypass;  // Pass raw samples when set
    } cfg_write_t;

endpackage

/* scaler_data_pkg.sv */
// Sample stream types for the scaler
// Input sample, lane input with gain attached, and lane or top output
`include "scaler_settings.svh"

package scaler_data_pkg;

    typedef logic signed [`SCALER_DATA_W-1:0] sample_t;  // Signed sample
    typedef logic [`SCALER_CHAN_W-1:0]        chan_t;    // Channel index

    // Sample tag
    typedef struct packed {
        logic   valid;  // Strobe, one cycle per sample
        chan_t  chan;   // Owning channel
    } tag_t;

    // Top-level input
    typedef struct packed {
        tag_t     tag;
        sample_t  data;
    } in_sample_t;

    // Dispatcher to lane
    typedef struct packed {
        tag_t                   tag;
        sample_t                data;
        scaler_cfg_pkg::gain_t  gain;    // Gain captured with the sample
        logic                   bypass;
    } lane_in_t;

    // Lane to collector, also the top-level output
    typedef struct packed {
        tag_t     tag;
        sample_t  data;  // Scaled or raw result
        logic     sat;   // Result was clamped
    } lane_out_t;

endpackage

/* delayline.sv */
// Clock-enabled delay line for any packed payload type
// LATENCY stages of T, all cleared by reset and frozen while clkena is low
`timescale 1ns/1ns

module delayline
#(
    parameter type          T       = logic [18:0],  // Payload type
    parameter int unsigned  LATENCY = 2              // Stages, 0 gives a wire
)
(
    // Reset and clock
    input  logic    reset,
    input  logic    clk,

    // Clock enable
    input  logic    clkena,

    // Payload in and out
    input  T        data,
    output T        q
);
    generate
        if (LATENCY > 1) begin : g_chain
            T delay_reg [LATENCY];  // Stage 0 is the input side

            always_ff @(posedge reset, posedge clk) begin
                if (reset) begin
                    for (int i = 0; i < LATENCY; i++)
                        delay_reg[i] <= '0;
                end
                else if (clkena) begin
                    delay_reg[0] <= data;
                    for (int i = 1; i < LATENCY; i++)
                        delay_reg[i] <= delay_reg[i-1];  // Shift one stage on
                end
            end

            assign q = delay_reg[LATENCY-1];
        end
        else if (LATENCY == 1) begin : g_single
            T delay_reg;  // Single stage

            always_ff @(posedge reset, posedge clk) begin
                if (reset)
                    delay_reg <= '0;
                else if (clkena)
                    delay_reg <= data;
            end

            assign q = delay_reg;
        end
        else begin : g_wire
            assign q = data;  // No delay
        end
    endgenerate

endmodule

/* lane_dispatch.sv */
// Gain bank and sample router
// Holds per-lane gain and bypass, and registers each sample into its lane
`timescale 1ns/1ns
`include "scaler_settings.svh"

module lane_dispatch (
    // Reset and clock
    input  logic                        reset,
    input  logic                        clk,

    // Clock enable
    input  logic                        clkena,

    // Sample and gain-bank write
    input  scaler_data_pkg::in_sample_t in_sample,
    input  scaler_cfg_pkg::cfg_write_t  cfg,

    // One input per lane
    output scaler_data_pkg::lane_in_t   lane_in [`SCALER_LANES]
);
    scaler_cfg_pkg::gain_t      gain_bank [`SCALER_LANES];  // Current gains
    logic [`SCALER_LANES-1:0]   bypass_bank;                // Current bypass bits

    logic [`SCALER_LANES-1:0]   valid_r;                    // One-hot lane strobe
    logic [`SCALER_LANES-1:0]   bypass_r;
    scaler_data_pkg::chan_t     chan_r;                     // Shared by all lanes
    scaler_data_pkg::sample_t   data_r;
    scaler_cfg_pkg::gain_t      gain_r [`SCALER_LANES];     // Gain frozen at capture

    // Bank writes ignore clkena and land at the next edge
    always_ff @(posedge reset, posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `SCALER_LANES; i++)
                gain_bank[i] <= scaler_cfg_pkg::GAIN_ONE;  // Unity gain
            bypass_bank <= '0;
        end
        else if (cfg.we) begin
            gain_bank[cfg.lane]   <= cfg.gain;
            bypass_bank[cfg.lane] <= cfg.bypass;
        end
    end

    // Routing strobes and bypass bits
    always_ff @(posedge reset, posedge clk) begin
        if (reset) begin
            valid_r  <= '0;
            bypass_r <= '0;
        end
        else if (clkena) begin
            for (int i = 0; i < `SCALER_LANES; i++)
                valid_r[i] <= in_sample.tag.valid &&
                              (in_sample.tag.chan == scaler_data_pkg::chan_t'(i));
            bypass_r <= bypass_bank;  // Old value if written this cycle
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (clkena) begin
            chan_r <= in_sample.tag.chan;
            data_r <= in_sample.data;
            for (int i = 0; i < `SCALER_LANES; i++)
                gain_r[i] <= gain_bank[i];
        end
    end

    always_comb begin
        for (int i = 0; i < `SCALER_LANES; i++) begin
            lane_in[i].tag.valid = valid_r[i];  // Only the addressed lane
            lane_in[i].tag.chan  = chan_r;
            lane_in[i].data      = data_r;
            lane_in[i].gain      = gain_r[i];
            lane_in[i].bypass    = bypass_r[i];
        end
    end

endmodule

/* gain_lane.sv */
// One scaling lane, product then round then saturate
// Tag and raw sample ride in delay lines matched to the three stages
`timescale 1ns/1ns
`include "scaler_settings.svh"

module gain_lane (
    // Reset and clock
    input  logic                        reset,
    input  logic                        clk,

    // Clock enable
    input  logic                        clkena,

    input  scaler_data_pkg::lane_in_t   lane_in,
    output scaler_data_pkg::lane_out_t  lane_out
);
    logic signed [`SCALER_PROD_W-1:0]       prod_s1;    // Full product
    logic signed [`SCALER_PROD_W-1:0]       prod_rnd;   // Product plus half LSB
    logic signed [`SCALER_PROD_W-1:0]       round_s2;   // Rounded and shifted
    logic [`SCALER_PROD_W-`SCALER_DATA_W:0] hi_bits;    // Sign bit and everything above
    logic                                   clip;
    scaler_data_pkg::sample_t               limit;      // Clamp value
    scaler_data_pkg::sample_t               res_s3;
    logic                                   sat_s3;
    logic                                   bypass_s1;
    logic                                   bypass_s2;
    logic                                   bypass_s3;
    scaler_data_pkg::tag_t                  tag_q;      // Tag aligned to stage 3
    scaler_data_pkg::sample_t               raw_q;      // Raw sample aligned to stage 3

    // Round half up then arithmetic shift
    assign prod_rnd = prod_s1 + (1 <<< (`SCALER_FRAC_BITS - 1));

    // Out of range when the top bits disagree with the sign
    assign hi_bits = round_s2[`SCALER_PROD_W-1:`SCALER_DATA_W-1];
    assign clip    = !((&hi_bits) || !(|hi_bits));
    assign limit   = round_s2[`SCALER_PROD_W-1] ?
                     {1'b1, {(`SCALER_DATA_W-1){1'b0}}} :   // Most negative
                     {1'b0, {(`SCALER_DATA_W-1){1'b1}}};    // Most positive

    // Arithmetic stages, payload only
    always_ff @(posedge clk) begin
        if (clkena) begin
            prod_s1  <= $signed(lane_in.data) * $signed(lane_in.gain);   // Stage 1
            round_s2 <= prod_rnd >>> `SCALER_FRAC_BITS;                  // Stage 2
            res_s3   <= clip ? limit : round_s2[`SCALER_DATA_W-1:0];     // Stage 3
        end
    end

    // Bypass pipe and sat flag
    always_ff @(posedge reset, posedge clk) begin
        if (reset) begin
            bypass_s1 <= 1'b0;
            bypass_s2 <= 1'b0;
            bypass_s3 <= 1'b0;
            sat_s3    <= 1'b0;
        end
        else if (clkena) begin
            bypass_s1 <= lane_in.bypass;
            bypass_s2 <= bypass_s1;
            bypass_s3 <= bypass_s2;
            sat_s3    <= clip && !bypass_s2;  // Never flag a bypassed sample
        end
    end

    // Depth must match the three stages above
    delayline #(
        .T          (scaler_data_pkg::tag_t),
        .LATENCY    (`SCALER_LANE_LAT)
    ) tag_dly (
        .reset      (reset),
        .clk        (clk),
        .clkena     (clkena),
        .data       (lane_in.tag),
        .q          (tag_q)
    );

    delayline #(
        .T          (scaler_data_pkg::sample_t),
        .LATENCY    (`SCALER_LANE_LAT)
    ) raw_dly (
        .reset      (reset),
        .clk        (clk),
        .clkena     (clkena),
        .data       (lane_in.data),
        .q          (raw_q)
    );

    assign lane_out.tag  = tag_q;
    assign lane_out.data = bypass_s3 ? raw_q : res_s3;  // Raw sample on bypass
    assign lane_out.sat  = sat_s3;

endmodule

/* lane_collect.sv */
// Merges the lane outputs into one registered stream
// At most one lane is valid per cycle since all lanes share one latency
`timescale 1ns/1ns
`include "scaler_settings.svh"

module lane_collect (
    // Reset and clock
    input  logic                        reset,
    input  logic                        clk,

    // Clock enable
    input  logic                        clkena,

    input  scaler_data_pkg::lane_out_t  lane_out [`SCALER_LANES],
    output scaler_data_pkg::lane_out_t  out
);
    scaler_data_pkg::lane_out_t sel;  // Valid lane, or all zero

    always_comb begin
        sel = '0;  // Idle gives valid low and sat clear
        for (int i = 0; i < `SCALER_LANES; i++) begin
            if (lane_out[i].tag.valid)
                sel = lane_out[i];
        end
    end

    // Output register
    always_ff @(posedge reset, posedge clk) begin
        if (reset)
            out <= '0;
        else if (clkena)
            out <= sel;
    end

endmodule

/* multi_gain_scaler.sv */
// Top level of the multi-channel gain scaler
// Dispatcher, one gain lane per channel, then the output collector
`timescale 1ns/1ns
`include "scaler_settings.svh"

module multi_gain_scaler (
    // Reset and clock
    input  logic                        reset,
    input  logic                        clk,

    // Freezes every stage when low
    input  logic                        clkena,

    // Sample in, gain-bank write
    input  scaler_data_pkg::in_sample_t in_sample,
    input  scaler_cfg_pkg::cfg_write_t  cfg,

    // Merged result stream
    output scaler_data_pkg::lane_out_t  out
);
    scaler_data_pkg::lane_in_t  lane_in  [`SCALER_LANES];  // Dispatcher to lanes
    scaler_data_pkg::lane_out_t lane_out [`SCALER_LANES];  // Lanes to collector

    lane_dispatch u_dispatch (
        .reset      (reset),
        .clk        (clk),
        .clkena     (clkena),
        .in_sample  (in_sample),
        .cfg        (cfg),
        .lane_in    (lane_in)
    );

    generate
        for (genvar i = 0; i < `SCALER_LANES; i++) begin : g_lane
            gain_lane u_lane (
                .reset      (reset),
                .clk        (clk),
                .clkena     (clkena),
                .lane_in    (lane_in[i]),
                .lane_out   (lane_out[i])
            );
        end
    endgenerate

    lane_collect u_collect (
        .reset      (reset),
        .clk        (clk),
        .clkena     (clkena),
        .lane_out   (lane_out),
        .out        (out)
    );

endmodule

/* scaler_asserts.sv */
// Concurrent checks on the scaler output stream
// Bound into every multi_gain_scaler instance by the bind at the bottom
`timescale 1ns/1ns

module scaler_asserts (
    input logic                       reset,
    input logic                       clk,
    input logic                       clkena,
    input scaler_data_pkg::lane_out_t out
);
    int unsigned fail_count = 0;  // Read by the testbench at the end

    // Nothing leaves the pipeline during reset
    out_idle_in_reset: assert property (@(posedge clk) reset |-> !out.tag.valid)
        else begin
            fail_count++;
            $error("out.tag.valid is high while reset is asserted");
        end

    // A frozen cycle leaves the output register untouched
    out_held_when_frozen: assert property (
        @(posedge clk) disable iff (reset) !clkena |=> $stable(out))
        else begin
            fail_count++;
            $error("out changed across a cycle with clkena low");
        end

    // Idle output never flags saturation
    no_sat_when_idle: assert property (@(posedge clk) !(out.sat && !out.tag.valid))
        else begin
            fail_count++;
            $error("out.sat is high while out.tag.valid is low");
        end

endmodule

bind multi_gain_scaler scaler_asserts u_asserts (
    .reset  (reset),
    .clk    (clk),
    .clkena (clkena),
    .out    (out)
);

/* tb_clock_gen.sv */
// Testbench clock and reset source
// 100 ns clock, reset held high through the first three rising edges
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD  = 50;  // 100 ns period
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 reset = 1'b0;  // Released clear of the edge
    end

endmodule

/* tb_multi_gain_scaler.sv */
// Self-checking testbench for the multi-channel gain scaler
// Random samples and gain writes, checked against a reference model in order
`timescale 1ns/1ns
`include "scaler_settings.svh"

module tb_multi_gain_scaler;
    localparam int CLK_PERIOD = 100;
    localparam int N_PLAIN    = 40;  // Unity gains
    localparam int N_GAIN     = 60;  // Random gains
    localparam int N_SAT      = 40;
    localparam int N_BYP      = 40;
    localparam int N_ENA      = 80;  // With clkena gaps
    localparam int N_SAME     = 8;   // Write plus sample pairs
    localparam int N_SAMPLES  = N_PLAIN + N_GAIN + N_SAT + N_BYP + N_ENA + 2 * N_SAME;
    localparam int WATCHDOG_CYCLES = N_SAMPLES * 5 + 200;  // Margin for writes and drain
    localparam int PIPE_EDGES = 5;   // Enabled edges, accept edge included
    localparam scaler_cfg_pkg::gain_t GAIN_MAX = (1 << (`SCALER_GAIN_W - 1)) - 1;
    localparam scaler_cfg_pkg::gain_t GAIN_MIN = -(1 << (`SCALER_GAIN_W - 1));

    typedef struct packed {
        scaler_data_pkg::chan_t   chan;
        scaler_data_pkg::sample_t data;
        logic                     sat;
        logic [31:0]              edge_no;  // Enabled edge that took the sample
    } expect_t;

    logic                        reset;
    logic                        clk;
    logic                        clkena;
    scaler_data_pkg::in_sample_t in_sample;
    scaler_cfg_pkg::cfg_write_t  cfg;
    scaler_data_pkg::lane_out_t  out;

    scaler_cfg_pkg::gain_t    gain_m [`SCALER_LANES] = '{default: 1 << `SCALER_FRAC_BITS};
    logic [`SCALER_LANES-1:0] bypass_m = '0;  // Bank model, reset state
    expect_t                  exp_q [$];
    logic [31:0]              rng_state = 32'h7c80_6455;
    logic [31:0]              en_edges = 0;
    logic                     edge_en;
    int                       mismatches = 0;
    int                       other_errors = 0;
    int                       checked = 0;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    multi_gain_scaler dut (
        .reset      (reset),
        .clk        (clk),
        .clkena     (clkena),
        .in_sample  (in_sample),
        .cfg        (cfg),
        .out        (out)
    );

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Result rule: bypass, or round half up, shift and clamp
    function automatic scaler_data_pkg::lane_out_t scale_ref(
        input scaler_data_pkg::sample_t d,
        input scaler_cfg_pkg::gain_t    g,
        input logic                     byp
    );
        scaler_data_pkg::lane_out_t r;
        longint                     p;
        longint                     max_v;
        longint                     min_v;
        r     = '0;
        max_v = (longint'(1) << (`SCALER_DATA_W - 1)) - 1;
        min_v = -(longint'(1) << (`SCALER_DATA_W - 1));
        p     = longint'(d) * longint'(g) + (longint'(1) << (`SCALER_FRAC_BITS - 1));
        p     = p >>> `SCALER_FRAC_BITS;
        if (byp) begin
            r.data = d;  // Raw, never saturated
        end
        else if (p > max_v || p < min_v) begin
            r.data = (p > max_v) ? scaler_data_pkg::sample_t'(max_v)
                                 : scaler_data_pkg::sample_t'(min_v);
            r.sat  = 1'b1;
        end
        else begin
            r.data = scaler_data_pkg::sample_t'(p);
        end
        return r;
    endfunction

    task automatic step();
        @(posedge clk);
        #10;  // Inputs change clear of the edge
    endtask

    // Single bank write, no sample
    task automatic write_gain(input int lane, input scaler_cfg_pkg::gain_t g, input logic byp);
        in_sample.tag.valid = 1'b0;
        cfg.we     = 1'b1;
        cfg.lane   = scaler_data_pkg::chan_t'(lane);
        cfg.gain   = g;
        cfg.bypass = byp;
        step();
        cfg.we = 1'b0;
    endtask

    task automatic random_samples(input int n, input logic gaps);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = xorshift32();
            clkena              = !gaps || (r[7:6] != 2'b00);  // About one cycle in four low
            in_sample.tag.valid = r[8] | r[9];
            in_sample.tag.chan  = scaler_data_pkg::chan_t'(r[15:10] % `SCALER_LANES);
            in_sample.data      = scaler_data_pkg::sample_t'(xorshift32()) >>> r[3:0];
            step();
        end
        clkena              = 1'b1;
        in_sample.tag.valid = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0] r;
        clkena    = 1'b1;
        in_sample = '0;
        cfg       = '0;
        @(negedge reset);
        step();
        random_samples(N_PLAIN, 1'b0);  // Default unity gains
        for (int l = 0; l < `SCALER_LANES; l++)
            write_gain(l, scaler_cfg_pkg::gain_t'(xorshift32()), 1'b0);  // Signs mixed
        random_samples(N_GAIN, 1'b0);
        write_gain(0, GAIN_MAX, 1'b0);
        write_gain(1, GAIN_MIN, 1'b0);
        write_gain(2, 1 << `SCALER_FRAC_BITS, 1'b0);
        write_gain(3 % `SCALER_LANES, 3 << `SCALER_FRAC_BITS, 1'b0);
        random_samples(N_SAT, 1'b0);
        write_gain(1, GAIN_MIN, 1'b1);  // Extreme gains, bypassed
        write_gain(3 % `SCALER_LANES, GAIN_MAX, 1'b1);
        random_samples(N_BYP, 1'b0);
        random_samples(N_ENA, 1'b1);
        for (int i = 0; i < N_SAME; i++) begin
            r = xorshift32();
            in_sample.tag.valid = 1'b1;
            in_sample.tag.chan  = scaler_data_pkg::chan_t'(r[5:0] % `SCALER_LANES);
            in_sample.data      = scaler_data_pkg::sample_t'(r[31:16]) >>> 4;
            cfg.we     = 1'b1;  // Same cycle as the sample
            cfg.lane   = in_sample.tag.chan;
            cfg.gain   = scaler_cfg_pkg::gain_t'(xorshift32());
            cfg.bypass = r[6];
            step();
            cfg.we         = 1'b0;
            in_sample.data = in_sample.data + 16'sd7;  // Next sample, new gain
            step();
            in_sample.tag.valid = 1'b0;
        end
        repeat (10) step();  // Drain
        assert (exp_q.size() == 0) else begin
            other_errors++;
            $display("%0d samples never reached the output", exp_q.size());
        end
        $display("Checked %0d samples: %0d mismatches, %0d other errors, %0d assertion failures",
                 checked, mismatches, other_errors, dut.u_asserts.fail_count);
        if (mismatches == 0 && other_errors == 0 && dut.u_asserts.fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Model update at the edge, output check half a cycle later
    always begin : compare
        scaler_data_pkg::lane_out_t ref_o;
        expect_t                    e;
        @(posedge clk);
        edge_en = clkena && !reset;
        if (edge_en) begin
            en_edges++;
            if (in_sample.tag.valid) begin
                ref_o     = scale_ref(in_sample.data, gain_m[in_sample.tag.chan],
                                      bypass_m[in_sample.tag.chan]);
                e.chan    = in_sample.tag.chan;
                e.data    = ref_o.data;
                e.sat     = ref_o.sat;
                e.edge_no = en_edges;
                exp_q.push_back(e);
            end
        end
        if (!reset && cfg.we) begin
            gain_m[cfg.lane]   = cfg.gain;  // After the sample took the old one
            bypass_m[cfg.lane] = cfg.bypass;
        end
        @(negedge clk);
        if (edge_en && out.tag.valid) begin
            assert (exp_q.size() != 0) else begin
                other_errors++;
                $display("Output valid at %0t ns with no sample pending", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                checked++;
                assert (out.tag.chan == e.chan) else begin
                    mismatches++;
                    $display("Mismatch at %0t ns: out.tag.chan got %0d expected %0d",
                             $time, out.tag.chan, e.chan);
                end
                assert (out.data == e.data) else begin
                    mismatches++;
                    $display("Mismatch at %0t ns: out.data got %0d expected %0d",
                             $time, $signed(out.data), $signed(e.data));
                end
                assert (out.sat == e.sat) else begin
                    mismatches++;
                    $display("Mismatch at %0t ns: out.sat got %0b expected %0b",
                             $time, out.sat, e.sat);
                end
                assert (en_edges - e.edge_no + 1 == PIPE_EDGES) else begin
                    other_errors++;
                    $display("Sample at %0t ns took %0d enabled edges instead of %0d",
                             $time, en_edges - e.edge_no + 1, PIPE_EDGES);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
scaler_cfg_pkg.sv
scaler_data_pkg.sv
delayline.sv
lane_dispatch.sv
gain_lane.sv
lane_collect.sv
multi_gain_scaler.sv
scaler_asserts.sv
tb_clock_gen.sv
tb_multi_gain_scaler.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scaler testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_multi_gain_scaler -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_multi_gain_scaler +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
    echo "Failure reported, see $LOG"
    exit 1
fi
echo "No failure in $LOG"
exit 0
